// File: hw/ft601_pkg.sv
package ft601_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    localparam int NUM_BUFS  = 3;   // buffers per bank
    localparam int BUF_DEPTH = 16;  // beats per buffer

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;    // one bus word
    typedef logic [3:0]  be_t;      // byte enables of a word
    typedef logic [35:0] beat_t;    // {be, word}, as stored and as on the pins

    typedef logic [1:0] buf_idx_t;  // buffer within a bank
    typedef logic [3:0] slot_t;     // beat within a buffer
    typedef logic [4:0] fill_t;     // 0 .. BUF_DEPTH

    // 245 sync fifo bus phases
    typedef enum logic [1:0] {
        bus_idle,
        bus_turn,   // bus turnaround, device gets the data lines
        bus_read,
        bus_write
    } bus_state_t;

    // ring order shared by both banks
    function automatic buf_idx_t next_buf(input buf_idx_t idx);
        buf_idx_t nxt;
        if (idx == buf_idx_t'(NUM_BUFS - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + 1'b1;
        end
        return nxt;
    endfunction

endpackage

// File: hw/ft601_beat_if.sv
interface ft601_beat_if import ft601_pkg::*; ();

    beat_t beat;    // head beat on the write link, pin beat on the read link
    logic  avail;   // sealed buffer to give, or free buffer to take
    logic  last;    // final beat the held buffer can give / take
    logic  strobe;  // moves one beat
    logic  open;    // controller holds a buffer
    logic  close;   // releases the held buffer

    // beat is driven by the bank on the write link and by the
    // controller on the read link, the other side only reads it
    modport bank (
        output avail,
        output last,
        output beat,
        input  strobe,
        input  open,
        input  close
    );

    modport ctrl (
        output strobe,
        output open,
        output close,
        output beat,
        input  avail,
        input  last
    );

endinterface

// File: hw/ft601_wr_bank.sv
module ft601_wr_bank import ft601_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      wr_data,
    input  be_t        wr_be,
    input  logic       wr_valid,
    input  logic       wr_push,
    output logic       wr_full,
    ft601_beat_if.bank bus
);

    beat_t               mem [NUM_BUFS][BUF_DEPTH];
    fill_t               cnt [NUM_BUFS];       // beats written so far
    slot_t               rd_slot [NUM_BUFS];   // next beat to drain, kept across stalls
    logic [NUM_BUFS-1:0] sealed;               // waiting for / under drain
    buf_idx_t            fill_idx;
    buf_idx_t            drain_idx;

    fill_t fill_now;
    logic  accept;
    logic  seal;
    logic  pop;

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////

    assign fill_now = cnt[fill_idx];
    assign wr_full  = sealed[fill_idx];  // ring wrapped onto an undrained buffer
    assign accept   = wr_valid && !wr_full;

    // seal on a full buffer or on push, an empty buffer stays open
    always_comb begin
        seal = 1'b0;
        if (!wr_full) begin
            if (wr_valid) begin
                seal = wr_push || (fill_now == fill_t'(BUF_DEPTH - 1));
            end else begin
                seal = wr_push && (fill_now != '0);
            end
        end
    end

    //////////////////////////////////////////////////
    // bus side
    //////////////////////////////////////////////////

    assign pop       = bus.open && bus.strobe;
    assign bus.avail = sealed[drain_idx];
    assign bus.beat  = mem[drain_idx][rd_slot[drain_idx]];  // head shown ahead of the strobe
    assign bus.last  = (fill_t'(rd_slot[drain_idx]) + 1'b1) == cnt[drain_idx];

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[fill_idx][slot_t'(fill_now)] <= {wr_be, wr_data};
        end
    end

    // fill side only touches an unsealed buffer, drain side only a
    // sealed one, so the two never hit the same entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_BUFS; i++) begin
                cnt[i]     <= '0;
                rd_slot[i] <= '0;
            end
            sealed    <= '0;
            fill_idx  <= '0;
            drain_idx <= '0;
        end else begin
            if (accept) begin
                cnt[fill_idx] <= fill_now + 1'b1;
            end
            if (seal) begin
                sealed[fill_idx] <= 1'b1;
                fill_idx         <= next_buf(fill_idx);
            end

            if (bus.close) begin
                // emptied, hand it back to the host
                cnt[drain_idx]     <= '0;
                rd_slot[drain_idx] <= '0;
                sealed[drain_idx]  <= 1'b0;
                drain_idx          <= next_buf(drain_idx);
            end else if (pop) begin
                rd_slot[drain_idx] <= rd_slot[drain_idx] + 1'b1;
            end
        end
    end

endmodule

// File: hw/ft601_bus_ctrl.sv
module ft601_bus_ctrl import ft601_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ft_txe_n,
    input  logic       ft_rxf_n,
    output logic       ft_wr_n,
    output logic       ft_rd_n,
    output logic       ft_oe_n,
    input  beat_t      ft_data_in,
    output beat_t      ft_data_out,
    output logic       ft_data_oe,
    ft601_beat_if.ctrl wr_link,
    ft601_beat_if.ctrl rd_link
);

    bus_state_t state;
    logic       pref_rd;    // read wins the next tie

    logic can_wr;
    logic can_rd;
    logic start_rd;
    logic start_wr;
    logic wr_drive;
    logic wr_take;
    logic wr_done;
    logic rd_take;
    logic rd_done;

    //////////////////////////////////////////////////
    // arbitration
    //////////////////////////////////////////////////

    assign can_wr   = !ft_txe_n && wr_link.avail;
    assign can_rd   = !ft_rxf_n && rd_link.avail;  // no free read buffer, no read
    assign start_rd = (state == bus_idle) && can_rd && (pref_rd || !can_wr);
    assign start_wr = (state == bus_idle) && can_wr && !start_rd;

    //////////////////////////////////////////////////
    // transfer qualifiers
    //////////////////////////////////////////////////

    assign wr_drive = (state == bus_write) && wr_link.avail;
    assign wr_take  = wr_drive && !ft_txe_n;        // device takes a word this edge
    assign wr_done  = wr_take && wr_link.last;
    assign rd_take  = (state == bus_read) && !ft_rxf_n;
    assign rd_done  = (state == bus_read) && (ft_rxf_n || rd_link.last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= bus_idle;
            pref_rd <= 1'b0;
        end else begin
            case (state)
                bus_idle: begin
                    if (start_rd) begin
                        state   <= bus_turn;
                        pref_rd <= 1'b0;
                    end else if (start_wr) begin
                        state   <= bus_write;
                        pref_rd <= 1'b1;
                    end
                end
                bus_turn: begin
                    state <= bus_read;
                end
                bus_read: begin
                    if (rd_done) begin
                        state <= bus_idle;
                    end
                end
                bus_write: begin
                    // done, or device full, partly drained buffer resumes later
                    if (wr_done || !wr_take) begin
                        state <= bus_idle;
                    end
                end
                default: begin
                    state <= bus_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // pin decode
    //////////////////////////////////////////////////

    always_comb begin
        case (state)
            bus_turn: begin
                ft_oe_n = 1'b0;
                ft_rd_n = 1'b1;
            end
            bus_read: begin
                ft_oe_n = 1'b0;
                ft_rd_n = 1'b0;
            end
            default: begin
                ft_oe_n = 1'b1;
                ft_rd_n = 1'b1;
            end
        endcase
    end

    assign ft_wr_n     = !wr_drive;
    assign ft_data_oe  = wr_drive;
    assign ft_data_out = wr_link.beat;

    // link strobes
    assign wr_link.strobe = wr_take;
    assign wr_link.open   = (state == bus_write);
    assign wr_link.close  = wr_done;

    assign rd_link.strobe = rd_take;
    assign rd_link.open   = (state == bus_turn) || (state == bus_read);
    assign rd_link.close  = rd_done;
    assign rd_link.beat   = ft_data_in;

endmodule

// File: hw/ft601_rd_bank.sv
module ft601_rd_bank import ft601_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rd_en,
    output word_t      rd_data,
    output be_t        rd_be,
    output logic       rd_valid,
    output logic       rd_empty,
    ft601_beat_if.bank bus
);

    beat_t               mem [NUM_BUFS][BUF_DEPTH];
    fill_t               cnt [NUM_BUFS];   // beats in a sealed buffer
    logic [NUM_BUFS-1:0] sealed;           // holds beats for the host
    buf_idx_t            fill_idx;
    buf_idx_t            rd_idx;
    slot_t               wr_slot;          // every burst starts a fresh buffer
    slot_t               rd_slot;

    logic  take;
    fill_t taken;
    logic  keep;
    logic  pop;
    logic  pop_last;

    //////////////////////////////////////////////////
    // bus side
    //////////////////////////////////////////////////

    assign take      = bus.open && bus.strobe;
    assign taken     = fill_t'(wr_slot) + fill_t'(take);  // includes a beat on the close edge
    assign keep      = bus.close && (taken != '0);         // empty burst seals nothing
    assign bus.avail = !sealed[fill_idx];
    assign bus.last  = (wr_slot == slot_t'(BUF_DEPTH - 1));

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////

    assign rd_empty = !sealed[rd_idx];
    assign pop      = rd_en && !rd_empty;
    assign pop_last = (fill_t'(rd_slot) + 1'b1) == cnt[rd_idx];

    always_ff @(posedge clk) begin
        if (take) begin
            mem[fill_idx][wr_slot] <= bus.beat;
        end
        if (pop) begin
            {rd_be, rd_data} <= mem[rd_idx][rd_slot];
        end
    end

    // bus sets sealed on a free buffer, host clears it on a sealed one
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_BUFS; i++) begin
                cnt[i] <= '0;
            end
            sealed   <= '0;
            fill_idx <= '0;
            rd_idx   <= '0;
            wr_slot  <= '0;
            rd_slot  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (bus.close) begin
                wr_slot <= '0;
            end else if (take) begin
                wr_slot <= wr_slot + 1'b1;
            end
            if (keep) begin
                cnt[fill_idx]    <= taken;
                sealed[fill_idx] <= 1'b1;
                fill_idx         <= next_buf(fill_idx);
            end

            rd_valid <= pop;  // one cycle after the accepted rd_en
            if (pop) begin
                if (pop_last) begin
                    // drained, free it for the bus
                    rd_slot        <= '0;
                    sealed[rd_idx] <= 1'b0;
                    rd_idx         <= next_buf(rd_idx);
                end else begin
                    rd_slot <= rd_slot + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/ft601_bridge.sv
module ft601_bridge import ft601_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    // device side, 245 sync fifo
    input  logic  ft_txe_n,
    input  logic  ft_rxf_n,
    output logic  ft_wr_n,
    output logic  ft_rd_n,
    output logic  ft_oe_n,
    input  beat_t ft_data_in,
    output beat_t ft_data_out,
    output logic  ft_data_oe,

    // host side
    input  word_t wr_data,
    input  be_t   wr_be,
    input  logic  wr_valid,
    input  logic  wr_push,
    output logic  wr_full,
    input  logic  rd_en,
    output word_t rd_data,
    output be_t   rd_be,
    output logic  rd_valid,
    output logic  rd_empty
);

    ft601_beat_if wr_link ();   // write buffers -> bus
    ft601_beat_if rd_link ();   // bus -> read buffers

    ft601_wr_bank wr_bank_i (
        .clk      (clk),
        .reset    (reset),
        .wr_data  (wr_data),
        .wr_be    (wr_be),
        .wr_valid (wr_valid),
        .wr_push  (wr_push),
        .wr_full  (wr_full),
        .bus      (wr_link.bank)
    );

    ft601_bus_ctrl bus_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .ft_txe_n    (ft_txe_n),
        .ft_rxf_n    (ft_rxf_n),
        .ft_wr_n     (ft_wr_n),
        .ft_rd_n     (ft_rd_n),
        .ft_oe_n     (ft_oe_n),
        .ft_data_in  (ft_data_in),
        .ft_data_out (ft_data_out),
        .ft_data_oe  (ft_data_oe),
        .wr_link     (wr_link.ctrl),
        .rd_link     (rd_link.ctrl)
    );

    ft601_rd_bank rd_bank_i (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_be    (rd_be),
        .rd_valid (rd_valid),
        .rd_empty (rd_empty),
        .bus      (rd_link.bank)
    );

endmodule

// File: verif/ft601_dev_model.sv
module ft601_dev_model import ft601_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output logic  ft_txe_n,
    output logic  ft_rxf_n,
    input  logic  ft_wr_n,
    input  logic  ft_rd_n,
    input  logic  ft_oe_n,
    input  beat_t ft_data_out,
    input  logic  ft_data_oe,
    input  logic  tx_on,        // device accepts words
    input  logic  tx_rand,      // random back-pressure on ft_txe_n
    input  logic  rx_on,        // device sources words
    input  int    rx_total,     // words the device has to give
    input  beat_t wr_expect,    // next beat of the host stream
    output int    wr_got,
    output int    rd_sent,
    output int    errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic prev_rd_n;
    logic prev_oe_n;
    int   rd_next;

    initial begin
        ft_txe_n  = 1'b1;
        ft_rxf_n  = 1'b1;
        wr_got    = 0;
        rd_sent   = 0;
        errors    = 0;
        prev_rd_n = 1'b1;
        prev_oe_n = 1'b1;
    end

    //////////////////////////////////////////////////
    // flag generation
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        rd_next = rd_sent + ((!ft_rd_n && !ft_rxf_n) ? 1 : 0);  // word given at this edge
        if (reset) begin
            ft_txe_n <= 1'b1;
            ft_rxf_n <= 1'b1;
        end else begin
            rd_sent <= rd_next;
            if (!tx_on) begin
                ft_txe_n <= 1'b1;
            end else if (tx_rand) begin
                ft_txe_n <= ($urandom % 8) == 0;
            end else begin
                ft_txe_n <= 1'b0;
            end
            // random bursts until the stream runs out
            if (!rx_on || rd_next >= rx_total) begin
                ft_rxf_n <= 1'b1;
            end else if (ft_rxf_n) begin
                ft_rxf_n <= ($urandom % 4) != 0;
            end else begin
                ft_rxf_n <= ($urandom % 8) == 0;
            end
        end
    end

    //////////////////////////////////////////////////
    // write data and bus rules
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset) begin
            if (!ft_wr_n && !ft_txe_n) begin
                if (ft_data_out !== wr_expect) begin
                    $display("ERR host_to_device beat %0d: expected %h, actual %h",
                             wr_got, wr_expect, ft_data_out);
                    errors = errors + 1;
                end
                wr_got <= wr_got + 1;
            end
            if (!ft_wr_n && !ft_oe_n) begin
                $display("bus rule broken: ft_wr_n and ft_oe_n are low together");
                errors = errors + 1;
            end
            if (prev_rd_n && !ft_rd_n && prev_oe_n) begin
                $display("bus rule broken: ft_rd_n fell without ft_oe_n low the cycle before");
                errors = errors + 1;
            end
            if (ft_data_oe !== (ft_oe_n && !ft_wr_n)) begin
                $display("bus rule broken: ft_data_oe does not follow ft_oe_n and ft_wr_n");
                errors = errors + 1;
            end
        end
        prev_rd_n <= ft_rd_n;
        prev_oe_n <= ft_oe_n;
    end

endmodule

// File: verif/tb_ft601_bridge.sv
module tb_ft601_bridge import ft601_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RX_TOTAL    = 600;
    localparam int RD_ROOM     = NUM_BUFS * BUF_DEPTH;  // beats the read bank can hold
    localparam int CYCLE_LIMIT = 20000;

    logic  clk;
    logic  reset;
    logic  ft_txe_n;
    logic  ft_rxf_n;
    logic  ft_wr_n;
    logic  ft_rd_n;
    logic  ft_oe_n;
    beat_t ft_data_in;
    beat_t ft_data_out;
    logic  ft_data_oe;
    word_t wr_data;
    be_t   wr_be;
    logic  wr_valid;
    logic  wr_push;
    logic  wr_full;
    logic  rd_en;
    word_t rd_data;
    be_t   rd_be;
    logic  rd_valid;
    logic  rd_empty;

    logic  tx_on;
    logic  tx_rand;
    logic  rx_on;
    beat_t wr_expect;
    int    wr_got;
    int    rd_sent;
    int    dev_errors;

    string test_name;
    int    errors;
    int    timeouts;
    int    cycles = 0;
    int    wr_idx;          // next host beat index
    int    buf_fill;        // beats in the write buffer being filled
    logic  seal_edge;       // the beat registered at the coming edge seals a buffer
    logic  full_banned;
    int    rd_got;
    logic  exp_valid;
    int    burst;           // beats of the read burst on the bus so far
    int    burst_now;       // same, with the beat given at the coming edge
    int    shown;           // beats sealed into read buffers
    int    popped;          // host pops that were accepted
    logic  exp_empty;

    // expected beat at a stream position of either direction
    function automatic beat_t gen_beat(input logic rd_dir, input int index);
        word_t w;
        be_t   be;
        w  = word_t'(index) * 32'h9e37_79b9 + (rd_dir ? 32'h5a5a_0f0f : 32'h0f0f_5a5a);
        be = index[3:0] ^ {rd_dir, 3'b101};
        return {be, w};
    endfunction

    assign ft_data_in = gen_beat(1'b1, rd_sent);
    assign wr_expect  = gen_beat(1'b0, wr_got);
    assign burst_now  = burst + (ft_rxf_n ? 0 : 1);
    assign exp_empty  = (shown == popped);

    ft601_bridge ft601_bridge_i (.*);

    ft601_dev_model dev_model_i (
        .rx_total (RX_TOTAL),
        .errors   (dev_errors),
        .*
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string what, input beat_t exp, input beat_t act);
        $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        errors = errors + 1;
    endtask

    //////////////////////////////////////////////////
    // host stimulus
    //////////////////////////////////////////////////

    // offers only when wr_full is known to stay low after the edge
    task automatic send_packet(input int len, input int gap);
        int sent;
        sent = 0;
        while (sent < len) begin
            @(posedge clk);
            if (full_banned && wr_full) begin
                $display("wr_full rose while the host stayed below the drain rate");
                errors = errors + 1;
            end
            if (!wr_full && !seal_edge && ($urandom % gap) == 0) begin
                {wr_be, wr_data} <= gen_beat(1'b0, wr_idx);
                wr_valid  <= 1'b1;
                wr_push   <= (sent == len - 1);
                seal_edge  = (sent == len - 1) || (buf_fill == BUF_DEPTH - 1);
                buf_fill   = seal_edge ? 0 : buf_fill + 1;
                wr_idx     = wr_idx + 1;
                sent       = sent + 1;
            end else begin
                wr_valid  <= 1'b0;
                wr_push   <= 1'b0;
                seal_edge  = 1'b0;
            end
        end
    endtask

    task automatic send_stream(input int total, input int gap);
        int start;
        start = wr_idx;
        while (wr_idx - start < total) begin
            send_packet(1 + ($urandom % 40), gap);
        end
        @(posedge clk);
        wr_valid  <= 1'b0;
        wr_push   <= 1'b0;
        seal_edge  = 1'b0;
    endtask

    task automatic read_until(input int target);
        while (rd_got < target) begin
            @(posedge clk);
            rd_en <= ($urandom % 2) == 0;
        end
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    // hold off until the read side has had data for a long stretch
    task automatic stall_reads();
        int low_run;
        low_run = 0;
        rd_en <= 1'b0;
        while (low_run < 200) begin
            @(posedge clk);
            low_run = rd_empty ? 0 : low_run + 1;
        end
    endtask

    //////////////////////////////////////////////////
    // read comparison
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            exp_valid <= 1'b0;
            rd_got    <= 0;
            burst     <= 0;
            shown     <= 0;
            popped    <= 0;
        end else begin
            if (rd_empty !== exp_empty) begin
                report_mismatch("rd_empty", beat_t'(exp_empty), beat_t'(rd_empty));
            end
            if (rd_valid !== exp_valid) begin
                report_mismatch("rd_valid", beat_t'(exp_valid), beat_t'(rd_valid));
            end
            if (rd_valid && ({rd_be, rd_data} !== gen_beat(1'b1, rd_got))) begin
                report_mismatch("read beat", gen_beat(1'b1, rd_got), {rd_be, rd_data});
            end
            if (rd_valid) begin
                rd_got <= rd_got + 1;
            end
            if (rd_sent - rd_got > RD_ROOM || (!ft_rd_n && rd_sent - rd_got >= RD_ROOM)) begin
                $display("ft_rd_n went low with every read buffer full");
                errors = errors + 1;
            end
            // a burst fills one read buffer and seals when it ends
            if (!ft_rd_n) begin
                if (ft_rxf_n || burst_now == BUF_DEPTH) begin
                    shown <= shown + burst_now;
                    burst <= 0;
                end else begin
                    burst <= burst_now;
                end
            end
            exp_valid <= rd_en && !exp_empty;   // accepted pop shows one cycle later
            popped    <= popped + ((rd_en && !exp_empty) ? 1 : 0);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            timeouts = timeouts + 1;
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d, timeouts: %0d", errors + dev_errors, timeouts);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        wr_data     = '0;
        wr_be       = '0;
        wr_valid    = 1'b0;
        wr_push     = 1'b0;
        rd_en       = 1'b0;
        tx_on       = 1'b0;
        tx_rand     = 1'b0;
        rx_on       = 1'b0;
        errors      = 0;
        timeouts    = 0;
        wr_idx      = 0;
        buf_fill    = 0;
        seal_edge   = 1'b0;
        full_banned = 1'b0;
        test_name   = "reset_state";
        void'($urandom(32'hc62c_1f02));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        if (ft_oe_n !== 1'b1) report_mismatch("ft_oe_n", beat_t'(1), beat_t'(ft_oe_n));
        if (ft_rd_n !== 1'b1) report_mismatch("ft_rd_n", beat_t'(1), beat_t'(ft_rd_n));
        if (ft_wr_n !== 1'b1) report_mismatch("ft_wr_n", beat_t'(1), beat_t'(ft_wr_n));
        if (ft_data_oe !== 1'b0) report_mismatch("ft_data_oe", '0, beat_t'(ft_data_oe));
        if (wr_full !== 1'b0) report_mismatch("wr_full", '0, beat_t'(wr_full));
        if (rd_valid !== 1'b0) report_mismatch("rd_valid", '0, beat_t'(rd_valid));
        if (rd_empty !== 1'b1) report_mismatch("rd_empty", beat_t'(1), beat_t'(rd_empty));

        test_name = "host_to_device";
        tx_on <= 1'b1;
        send_stream(200, 1);
        test_name   = "device_backpressure";
        tx_rand    <= 1'b1;
        full_banned = 1'b1;
        send_stream(200, 8);
        full_banned = 1'b0;
        while (wr_got != wr_idx) @(posedge clk);

        test_name = "device_to_host";
        rx_on <= 1'b1;
        read_until(200);
        test_name = "host_read_stall";
        stall_reads();
        read_until(400);

        test_name = "mixed_traffic";
        fork
            send_stream(200, 2);
            read_until(RX_TOTAL);
        join
        while (wr_got != wr_idx) @(posedge clk);
        repeat (8) @(posedge clk);
        if (rd_empty !== 1'b1) report_mismatch("rd_empty", beat_t'(1), beat_t'(rd_empty));
        if (rd_got != RX_TOTAL) report_mismatch("read count", beat_t'(RX_TOTAL), beat_t'(rd_got));

        $display("errors: %0d, timeouts: %0d", errors + dev_errors, timeouts);
        if (errors + dev_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/ft601_pkg.sv
hw/ft601_beat_if.sv
hw/ft601_wr_bank.sv
hw/ft601_bus_ctrl.sv
hw/ft601_rd_bank.sv
hw/ft601_bridge.sv
verif/ft601_dev_model.sv
verif/tb_ft601_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ft601 bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_ft601_bridge -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_ft601_bridge)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
